// File: sched_pkg.sv
package sched_pkg;

    // datapath widths
    localparam int V_ID_WIDTH    = 32;
    localparam int V_VALUE_WIDTH = 32;

    // buffer sizing, one depth for all three FIFOs
    localparam int FIFO_DEPTH      = 16;
    localparam int FIFO_CNT_WIDTH  = 5;
    localparam int PROG_FULL_LEVEL = 12;

    // high-degree vertices whose edge value is replaced by the vertex id
    localparam int POWERLAW_VTX_NUM = 4;

    // entry 0 is the rightmost word
    localparam logic [POWERLAW_VTX_NUM-1:0][V_ID_WIDTH-1:0] POWERLAW_VTX = {
        32'd9636,
        32'd9395,
        32'd1355,
        32'd2472
    };

    // push record with this id is dropped
    localparam logic [V_ID_WIDTH-1:0] NO_EDGE_ID = '1;

    // push stream record, edge arrives on its own port
    typedef struct packed {
        logic                     push;
        logic [V_ID_WIDTH-1:0]    id;
        logic [V_VALUE_WIDTH-1:0] value;
    } push_rec_t;

    // pull stream record carries its edge target
    typedef struct packed {
        logic                     push;
        logic [V_ID_WIDTH-1:0]    id;
        logic [V_VALUE_WIDTH-1:0] value;
        logic [V_ID_WIDTH-1:0]    edge_id;
    } pull_rec_t;

    // one vertex update towards the next stage
    typedef struct packed {
        logic                     push;
        logic [V_ID_WIDTH-1:0]    id;
        logic [V_VALUE_WIDTH-1:0] value;
        logic                     pull_first;
    } update_t;

endpackage

// File: sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo
    import sched_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  payload_t                  wr_data,
    input  logic                      rd_en,
    output payload_t                  rd_data,
    output logic                      empty,
    output logic [FIFO_CNT_WIDTH-1:0] count,
    output logic                      prog_full
);

    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    payload_t                      mem [FIFO_DEPTH];
    logic                          wr_ok;
    logic                          rd_ok;

    // a write into a full buffer is dropped
    assign wr_ok = wr_en && (count != FIFO_CNT_WIDTH'(FIFO_DEPTH));
    assign rd_ok = rd_en && !empty;

    // storage
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // show-ahead head of queue
    assign rd_data   = mem[rd_ptr];
    assign empty     = (count == '0);
    assign prog_full = (count >= FIFO_CNT_WIDTH'(PROG_FULL_LEVEL));

endmodule

// File: sched_input.sv
`timescale 1ns/1ps

module sched_input
    import sched_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    // push stream, record and edge written independently
    input  push_rec_t                 push_rec,
    input  logic                      push_rec_valid,
    input  logic [V_ID_WIDTH-1:0]     push_edge,
    input  logic                      push_edge_valid,

    // pull stream
    input  pull_rec_t                 pull_rec,
    input  logic                      pull_rec_valid,

    // pops from the processing part
    input  logic                      push_pop,
    input  logic                      pull_pop,

    output push_rec_t                 push_head,
    output logic [V_ID_WIDTH-1:0]     edge_head,
    output pull_rec_t                 pull_head,
    output logic                      push_rec_empty,
    output logic                      edge_empty,
    output logic                      pull_empty,
    output logic [FIFO_CNT_WIDTH-1:0] edge_count,
    output logic [FIFO_CNT_WIDTH-1:0] pull_count,
    output logic                      stage_full_push,
    output logic                      stage_full_pull
);

    // push records, threshold goes back to the push front
    sync_fifo #(
        .payload_t (push_rec_t)
    ) push_rec_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (push_rec_valid),
        .wr_data   (push_rec),
        .rd_en     (push_pop),
        .rd_data   (push_head),
        .empty     (push_rec_empty),
        .count     (),
        .prog_full (stage_full_push)
    );

    // push edges, popped together with the records
    sync_fifo #(
        .payload_t (logic [V_ID_WIDTH-1:0])
    ) push_edge_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (push_edge_valid),
        .wr_data   (push_edge),
        .rd_en     (push_pop),
        .rd_data   (edge_head),
        .empty     (edge_empty),
        .count     (edge_count),
        .prog_full ()
    );

    // pull records
    sync_fifo #(
        .payload_t (pull_rec_t)
    ) pull_rec_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (pull_rec_valid),
        .wr_data   (pull_rec),
        .rd_en     (pull_pop),
        .rd_data   (pull_head),
        .empty     (pull_empty),
        .count     (pull_count),
        .prog_full (stage_full_pull)
    );

endmodule

// File: sched_select.sv
`timescale 1ns/1ps

module sched_select
    import sched_pkg::*;
(
    input  push_rec_t                 push_head,
    input  logic [V_ID_WIDTH-1:0]     edge_head,
    input  pull_rec_t                 pull_head,
    input  logic                      push_rec_empty,
    input  logic                      edge_empty,
    input  logic                      pull_empty,
    input  logic [FIFO_CNT_WIDTH-1:0] edge_count,
    input  logic [FIFO_CNT_WIDTH-1:0] pull_count,
    input  logic                      next_stage_full,
    output logic                      push_pop,
    output logic                      pull_pop,
    output update_t                   next_update,
    output logic                      next_update_valid
);

    logic push_sel;
    logic pull_sel;
    logic push_edge_pl;
    logic pull_edge_pl;

    // true when the edge target is one of the high-degree vertices
    function automatic logic is_powerlaw(input logic [V_ID_WIDTH-1:0] vid);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < POWERLAW_VTX_NUM; i++) begin
            if (vid == POWERLAW_VTX[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // fuller edge buffer wins, ties go to the pull stream
    assign push_sel = !next_stage_full && !push_rec_empty && !edge_empty &&
                      (edge_count > pull_count);
    assign pull_sel = !next_stage_full && !pull_empty &&
                      (edge_count <= pull_count);

    assign push_pop = push_sel;
    assign pull_pop = pull_sel;

    assign push_edge_pl = is_powerlaw(edge_head);
    assign pull_edge_pl = is_powerlaw(pull_head.edge_id);

    always_comb begin
        next_update       = '0;
        next_update_valid = 1'b0;
        if (push_sel) begin
            if (push_head.push) begin
                // NO_EDGE_ID marks a vertex without out-edges, consumed silently
                if (push_head.id != NO_EDGE_ID) begin
                    next_update.push       = 1'b1;
                    next_update.id         = edge_head;
                    next_update.value      = push_head.value;
                    next_update.pull_first = 1'b0;
                    next_update_valid      = 1'b1;
                end
            end else begin
                next_update.push       = 1'b0;
                next_update.id         = push_head.id;
                next_update.value      = push_edge_pl ? push_head.id : edge_head;
                next_update.pull_first = 1'b0;
                next_update_valid      = 1'b1;
            end
        end else if (pull_sel) begin
            next_update.push       = pull_head.push;
            next_update.id         = pull_head.id;
            next_update.value      = pull_edge_pl ? pull_head.id : pull_head.edge_id;
            next_update.pull_first = 1'b1;
            next_update_valid      = 1'b1;
        end
    end

endmodule

// File: sched_output.sv
`timescale 1ns/1ps

module sched_output
    import sched_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  update_t next_update,
    input  logic    next_update_valid,
    input  logic    push_end,
    input  logic    pull_end,
    input  logic    push_rec_empty,
    input  logic    pull_empty,
    output update_t update,
    output logic    update_valid,
    output logic    iteration_end
);

    logic drained_end;

    // both fronts done and nothing left in the buffers
    assign drained_end = push_end && pull_end && push_rec_empty && pull_empty;

    // processing part drives all-zero fields whenever no update is issued
    always_ff @(posedge clk) begin
        update <= next_update;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            update_valid <= 1'b0;
        end else begin
            update_valid <= next_update_valid;
        end
    end

    // one-cycle end of iteration
    always_ff @(posedge clk) begin
        if (rst) begin
            iteration_end <= 1'b0;
        end else begin
            iteration_end <= drained_end;
        end
    end

endmodule

// File: scheduler_top.sv
`timescale 1ns/1ps

module scheduler_top
    import sched_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  push_rec_t             push_rec,
    input  logic                  push_rec_valid,
    input  logic [V_ID_WIDTH-1:0] push_edge,
    input  logic                  push_edge_valid,
    input  pull_rec_t             pull_rec,
    input  logic                  pull_rec_valid,
    input  logic                  push_end,
    input  logic                  pull_end,
    input  logic                  next_stage_full,
    output logic                  stage_full_push,
    output logic                  stage_full_pull,
    output update_t               update,
    output logic                  update_valid,
    output logic                  iteration_end
);

    push_rec_t                 push_head;
    logic [V_ID_WIDTH-1:0]     edge_head;
    pull_rec_t                 pull_head;
    logic                      push_rec_empty;
    logic                      edge_empty;
    logic                      pull_empty;
    logic [FIFO_CNT_WIDTH-1:0] edge_count;
    logic [FIFO_CNT_WIDTH-1:0] pull_count;
    logic                      push_pop;
    logic                      pull_pop;
    update_t                   next_update;
    logic                      next_update_valid;

    sched_input sched_input_inst (
        .clk             (clk),
        .rst             (rst),
        .push_rec        (push_rec),
        .push_rec_valid  (push_rec_valid),
        .push_edge       (push_edge),
        .push_edge_valid (push_edge_valid),
        .pull_rec        (pull_rec),
        .pull_rec_valid  (pull_rec_valid),
        .push_pop        (push_pop),
        .pull_pop        (pull_pop),
        .push_head       (push_head),
        .edge_head       (edge_head),
        .pull_head       (pull_head),
        .push_rec_empty  (push_rec_empty),
        .edge_empty      (edge_empty),
        .pull_empty      (pull_empty),
        .edge_count      (edge_count),
        .pull_count      (pull_count),
        .stage_full_push (stage_full_push),
        .stage_full_pull (stage_full_pull)
    );

    sched_select sched_select_inst (
        .push_head         (push_head),
        .edge_head         (edge_head),
        .pull_head         (pull_head),
        .push_rec_empty    (push_rec_empty),
        .edge_empty        (edge_empty),
        .pull_empty        (pull_empty),
        .edge_count        (edge_count),
        .pull_count        (pull_count),
        .next_stage_full   (next_stage_full),
        .push_pop          (push_pop),
        .pull_pop          (pull_pop),
        .next_update       (next_update),
        .next_update_valid (next_update_valid)
    );

    sched_output sched_output_inst (
        .clk               (clk),
        .rst               (rst),
        .next_update       (next_update),
        .next_update_valid (next_update_valid),
        .push_end          (push_end),
        .pull_end          (pull_end),
        .push_rec_empty    (push_rec_empty),
        .pull_empty        (pull_empty),
        .update            (update),
        .update_valid      (update_valid),
        .iteration_end     (iteration_end)
    );

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker
    import sched_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  push_rec_t             push_rec,
    input  logic                  push_rec_valid,
    input  logic [V_ID_WIDTH-1:0] push_edge,
    input  logic                  push_edge_valid,
    input  pull_rec_t             pull_rec,
    input  logic                  pull_rec_valid,
    input  logic                  push_end,
    input  logic                  pull_end,
    input  logic                  next_stage_full,
    input  logic                  stage_full_push,
    input  logic                  stage_full_pull,
    input  update_t               update,
    input  logic                  update_valid,
    input  logic                  iteration_end,
    // flag check request from the stimulus side
    // flags_expected bit 0 is push and bit 1 is pull
    input  logic                  check_flags,
    input  logic [1:0]            flags_expected,
    output int                    error_count,
    output int                    update_count,
    output logic                  drained
);

    update_t push_q[$];
    update_t pull_q[$];
    logic    end_expected;
    logic    held;

    function automatic logic on_powerlaw_list(input logic [V_ID_WIDTH-1:0] vid);
        logic found;
        found = 1'b0;
        for (int i = 0; i < POWERLAW_VTX_NUM; i++) begin
            if (POWERLAW_VTX[i] == vid) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // push flag set sends the value to the edge target
    function automatic update_t push_prediction(input push_rec_t rec,
                                                input logic [V_ID_WIDTH-1:0] tgt);
        if (rec.push) begin
            return {1'b1, tgt, rec.value, 1'b0};
        end
        return {1'b0, rec.id, on_powerlaw_list(tgt) ? rec.id : tgt, 1'b0};
    endfunction

    function automatic update_t pull_prediction(input pull_rec_t rec);
        return {rec.push, rec.id, on_powerlaw_list(rec.edge_id) ? rec.id : rec.edge_id, 1'b1};
    endfunction

    task automatic mismatch(input string name, input logic [63:0] exp_val,
                            input logic [63:0] got_val);
        $display("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp_val, got_val);
        error_count++;
    endtask

    task automatic failure(input string msg);
        $display("at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic compare_update(input update_t exp_upd);
        if (update.push !== exp_upd.push) begin
            mismatch("update.push", exp_upd.push, update.push);
        end
        if (update.id !== exp_upd.id) begin
            mismatch("update.id", exp_upd.id, update.id);
        end
        if (update.value !== exp_upd.value) begin
            mismatch("update.value", exp_upd.value, update.value);
        end
    endtask

    initial begin
        error_count = 0;
        update_count = 0;
    end

    // mid-cycle sample where inputs and outputs are both stable
    always @(negedge clk) begin
        if (rst) begin
            push_q.delete();
            pull_q.delete();
            end_expected = 1'b0;
            held = 1'b0;
        end else begin
            if (update_valid) begin
                update_count++;
                if (held) begin
                    failure("an update was issued while the next stage was full");
                end
                if (update.pull_first && pull_q.size() != 0) begin
                    compare_update(pull_q.pop_front());
                end else if (!update.pull_first && push_q.size() != 0) begin
                    compare_update(push_q.pop_front());
                end else begin
                    failure("an update arrived with no entry expected on its stream");
                end
            end else if (update !== '0) begin
                failure("the update fields are not cleared while update_valid is low");
            end
            if (iteration_end !== end_expected) begin
                mismatch("iteration_end", end_expected, iteration_end);
            end
            if (check_flags && stage_full_push !== flags_expected[0]) begin
                mismatch("stage_full_push", flags_expected[0], stage_full_push);
            end
            if (check_flags && stage_full_pull !== flags_expected[1]) begin
                mismatch("stage_full_pull", flags_expected[1], stage_full_pull);
            end
            // buffers hold exactly what is still expected
            end_expected = push_end && pull_end && push_q.size() == 0 && pull_q.size() == 0;
            if (push_rec_valid && push_edge_valid &&
                !(push_rec.push && push_rec.id == NO_EDGE_ID)) begin
                push_q.push_back(push_prediction(push_rec, push_edge));
            end
            if (pull_rec_valid) begin
                pull_q.push_back(pull_prediction(pull_rec));
            end
            held = next_stage_full;
        end
        drained = (push_q.size() == 0) && (pull_q.size() == 0);
    end

endmodule

// File: tb_scheduler.sv
`timescale 1ns/1ps

module tb_scheduler
    import sched_pkg::*;
();

    localparam int NUM_TESTS   = 6;
    localparam int DRAIN_LIMIT = 400;

    // one stimulus row, sel bit 0 push stream, bit 1 pull stream
    typedef struct packed {
        logic [3:0]               test;
        logic                     drain;
        logic [1:0]               sel;
        logic                     push;
        logic [V_ID_WIDTH-1:0]    id;
        logic [V_VALUE_WIDTH-1:0] value;
        logic [V_ID_WIDTH-1:0]    edge_id;
        logic [7:0]               hold;
        logic [1:0]               ends;
    } stim_row_t;

    logic                  clk;
    logic                  rst;
    push_rec_t             push_rec;
    logic                  push_rec_valid;
    logic [V_ID_WIDTH-1:0] push_edge;
    logic                  push_edge_valid;
    pull_rec_t             pull_rec;
    logic                  pull_rec_valid;
    logic                  push_end;
    logic                  pull_end;
    logic                  next_stage_full;
    logic                  stage_full_push;
    logic                  stage_full_pull;
    update_t               update;
    logic                  update_valid;
    logic                  iteration_end;
    logic                  check_flags;
    logic [1:0]            flags_expected;
    int                    error_count;
    int                    update_count;
    logic                  drained;
    stim_row_t             stim_rows[$];
    logic [31:0]           lcg_state = 32'h61ed1920;
    int                    bp_left;
    int                    push_writes;
    int                    pull_writes;
    int                    failed_tests;
    int                    tests_run;
    int                    errors_before;
    logic                  timed_out;

    scheduler_top scheduler_top_inst (.*);

    tb_checker tb_checker_inst (.*);

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // keeps filler ids clear of the all-ones marker
    function automatic logic [31:0] filler_id();
        return next_random() & 32'h00ff_ffff;
    endfunction

    task automatic add_row(input int test, input logic drain, input logic [1:0] sel,
                           input logic push, input logic [V_ID_WIDTH-1:0] id,
                           input logic [V_ID_WIDTH-1:0] edge_id, input int hold,
                           input logic [1:0] ends);
        stim_rows.push_back({4'(test), drain, sel, push, id, next_random(), edge_id,
                             8'(hold), ends});
    endtask

    task automatic build_stimulus();
        for (int i = 0; i < 6; i++) begin
            add_row(1, 0, 2'b01, 1, filler_id(), (i == 3) ? POWERLAW_VTX[1] : filler_id(), 0, 0);
        end
        for (int i = 0; i < 8; i++) begin
            add_row(2, 0, 2'b01, 0, filler_id(), (i % 2 == 0) ? POWERLAW_VTX[i / 2] : filler_id(),
                    0, 0);
        end
        // two dropped records, neither of them last
        for (int i = 0; i < 7; i++) begin
            add_row(3, 0, 2'b01, 1, (i == 2 || i == 5) ? NO_EDGE_ID : filler_id(), filler_id(),
                    0, 0);
        end
        for (int i = 0; i < 12; i++) begin
            add_row(4, 0, (i % 3 == 0) ? 2'b10 : ((i % 3 == 1) ? 2'b11 : 2'b01), 1'(i % 2),
                    filler_id(), (i % 4 == 0) ? POWERLAW_VTX[i / 4] : filler_id(), 0, 0);
        end
        for (int i = 0; i < 14; i++) begin
            add_row(5, 0, 2'b11, 1'(i % 2), filler_id(),
                    (i % 3 == 0) ? POWERLAW_VTX[i % 4] : filler_id(), (i == 0) ? 20 : 0, 0);
        end
        // end strobes once with entries held back, once after draining
        add_row(6, 0, 2'b11, 1, filler_id(), POWERLAW_VTX[3], 6, 0);
        add_row(6, 0, 2'b11, 0, filler_id(), filler_id(), 0, 0);
        add_row(6, 0, 2'b00, 0, '0, '0, 0, 2'b11);
        add_row(6, 1, 2'b00, 0, '0, '0, 0, 2'b11);
    endtask

    // drives one row for one cycle, back-pressure counts down across rows
    task automatic apply_row(input stim_row_t r);
        if (r.hold != 0) begin
            bp_left = r.hold;
            push_writes = 0;
            pull_writes = 0;
        end
        // nothing is popped during a hold, so the write counts are the fill levels
        check_flags = (bp_left == 1);
        flags_expected = {pull_writes >= PROG_FULL_LEVEL, push_writes >= PROG_FULL_LEVEL};
        next_stage_full = (bp_left != 0);
        push_rec_valid = r.sel[0];
        push_edge_valid = r.sel[0];
        push_rec = {r.push, r.id, r.value};
        push_edge = r.edge_id;
        pull_rec_valid = r.sel[1];
        pull_rec = {r.push, r.id, r.value, r.edge_id};
        {pull_end, push_end} = r.ends;
        push_writes += r.sel[0];
        pull_writes += r.sel[1];
        @(posedge clk);
        #2;
        if (bp_left != 0) begin
            bp_left--;
        end
    endtask

    task automatic wait_drain(input int test);
        int cycles;
        cycles = 0;
        while (!(drained && bp_left == 0) && cycles < DRAIN_LIMIT) begin
            apply_row('0);
            cycles++;
        end
        if (!(drained && bp_left == 0)) begin
            $display("test %0d: timed out after %0d cycles waiting for the DUT to drain",
                     test, DRAIN_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        push_rec = '0;
        push_rec_valid = 1'b0;
        push_edge = '0;
        push_edge_valid = 1'b0;
        pull_rec = '0;
        pull_rec_valid = 1'b0;
        push_end = 1'b0;
        pull_end = 1'b0;
        next_stage_full = 1'b0;
        check_flags = 1'b0;
        flags_expected = 2'b00;
        bp_left = 0;
        push_writes = 0;
        pull_writes = 0;
        failed_tests = 0;
        tests_run = 0;
        timed_out = 1'b0;
        build_stimulus();
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        // both stage-full flags low right after reset
        check_flags = 1'b1;
        @(posedge clk);
        #2;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            if (!timed_out) begin
                errors_before = error_count;
                foreach (stim_rows[i]) begin
                    if (stim_rows[i].test == t && stim_rows[i].drain && !timed_out) begin
                        wait_drain(t);
                    end
                    if (stim_rows[i].test == t && !timed_out) begin
                        apply_row(stim_rows[i]);
                    end
                end
                if (!timed_out) begin
                    wait_drain(t);
                end
                repeat (3) apply_row('0);
                tests_run++;
                if (timed_out || error_count != errors_before) begin
                    failed_tests++;
                end
                $display("test %0d finished with %0d errors", t, error_count - errors_before);
            end
        end
        $display("tests run: %0d, failed: %0d, updates checked: %0d, errors: %0d",
                 tests_run, failed_tests, update_count, error_count);
        if (failed_tests == 0 && error_count == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: sources.f
sched_pkg.sv
sync_fifo.sv
sched_input.sv
sched_select.sv
sched_output.sv
scheduler_top.sv
tb_checker.sv
tb_scheduler.sv

// File: Bender.yml
package:
  name: graph_update_scheduler

sources:
  - sched_pkg.sv
  - sync_fifo.sv
  - sched_input.sv
  - sched_select.sv
  - sched_output.sv
  - scheduler_top.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_scheduler.sv
